// ==== all.f ====
+incdir+source
source/busPkg.sv
source/fetchPkg.sv
source/parcelPopIf.sv
source/fetchBusMaster.sv
source/parcelFifo.sv
source/instructionAligner.sv
source/instructionFetchUnit.sv
dv/clockGen.sv
dv/fetchAsserts.sv
dv/fetchTb.sv

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod  = 20,
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Released on a rising edge like the other inputs
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule : clockGen

`default_nettype wire

// ==== dv/fetchAsserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetchAsserts #(
    parameter int depth = `PARCEL_FIFO_DEPTH
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   wbCyc,
    input logic                   wbStb,
    input logic                   wbAck,
    input busPkg::addrT           wbAdr,
    input logic [$clog2(depth):0] fifoCount,
    input logic                   pushFire,
    input logic [1:0]             popCount
);

    // Request held with a stable address until acknowledged
    assert property (@(posedge clk) disable iff (reset)
        wbCyc && !wbAck |=> wbCyc && wbStb && $stable(wbAdr))
        else $error("Wishbone request dropped or address moved before wbAck");

    assert property (@(posedge clk) disable iff (reset)
        wbCyc && wbAck |=> !wbCyc && !wbStb)
        else $error("Wishbone cycle still open after wbAck");

    assert property (@(posedge clk) disable iff (reset) 32'(fifoCount) <= depth)
        else $error("FIFO count above depth");

    assert property (@(posedge clk) disable iff (reset) pushFire |-> 32'(fifoCount) < depth)
        else $error("Push into a full FIFO");

    assert property (@(posedge clk) disable iff (reset) 32'(popCount) <= 32'(fifoCount))
        else $error("Pop of more entries than the FIFO holds");

endmodule : fetchAsserts

// Bus side, FIFO ports tied off
bind fetchBusMaster fetchAsserts i_busAsserts (
    .clk       (clk),
    .reset     (reset),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbAck     (wbAck),
    .wbAdr     (wbAdr),
    .fifoCount ('0),
    .pushFire  (1'b0),
    .popCount  (2'b00)
);

bind parcelFifo fetchAsserts i_fifoAsserts (
    .clk       (clk),
    .reset     (reset),
    .wbCyc     (1'b0),
    .wbStb     (1'b0),
    .wbAck     (1'b0),
    .wbAdr     ('0),
    .fifoCount (count),
    .pushFire  (pushFire),
    .popCount  (popCount)
);

`default_nettype wire

// ==== dv/fetchTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetchTb;

    localparam int          memWords   = 64;
    localparam int          cycleLimit = 20 * memWords + 200;
    localparam logic [31:0] seed       = 32'hf83f;

    logic                  clk;
    logic                  reset;
    logic                  wbCyc;
    logic                  wbStb;
    logic                  wbWe;
    busPkg::addrT          wbAdr;
    busPkg::selT           wbSel;
    busPkg::wordT          wbDatIn = '0;
    logic                  wbAck = 1'b0;
    logic                  insValid;
    logic                  insReady = 1'b0;
    logic [31:0]           insWord;
    logic                  insCompressed;
    busPkg::addrT          insPc;

    busPkg::wordT          mem [memWords];
    logic [31:0]           stimState = seed;
    logic [1:0]            waitLeft = '0;
    logic                  inCycle = 1'b0;
    int                    cycleCount = 0;
    int                    numInstr = 0;
    int                    accepted = 0;
    int                    acks = 0;
    int                    parcelsOut = 0;
    int                    valueErrors = 0;
    int                    otherErrors = 0;
    busPkg::addrT          lastPc = '0;
    logic                  lastCompressed = 1'b0;
    fetchPkg::instructionT expected;

    clockGen #(
        .halfPeriod  (20),
        .resetCycles (10)
    ) i_clockGen (
        .clk   (clk),
        .reset (reset)
    );

    instructionFetchUnit i_instructionFetchUnit (.*);

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic fetchPkg::parcelT parcelAt(int idx);
        busPkg::wordT w;
        w = mem[6'(idx / 2)];
        return (idx % 2 == 1) ? w[31:16] : w[15:0];
    endfunction

    // Walks the image from the reset address up to instruction n
    function automatic fetchPkg::instructionT expectedInstr(int n);
        fetchPkg::instructionT ins;
        fetchPkg::parcelT      lo;
        int                    pos;
        pos = 0;
        ins = '0;
        for (int i = 0; i <= n; i++) begin
            lo               = parcelAt(pos);
            ins.pc           = `FETCH_RESET_ADDR + 32'(2 * pos);
            ins.isCompressed = lo[1:0] != fetchPkg::fullLengthCode;
            ins.word         = ins.isCompressed ? {16'h0000, lo} : {parcelAt(pos + 1), lo};
            pos += ins.isCompressed ? 1 : 2;
        end
        return ins;
    endfunction

    // Cycles into a consumer stall, -1 outside
    function automatic int stallAge(int cycle);
        if (cycle >= 150 && cycle < 350) begin
            return cycle - 150;
        end
        if (cycle >= 450 && cycle < 570) begin
            return cycle - 450;
        end
        return -1;
    endfunction

    task automatic reportMismatch(string name, logic [31:0] exp, logic [31:0] act);
        valueErrors++;
        $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Wishbone slave with 0 to 3 wait states, random consumer
    always @(posedge clk) begin
        stimState = xorshift(stimState);
        if (reset || wbAck) begin
            wbAck   <= 1'b0;
            inCycle <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (inCycle ? waitLeft == 2'd0 : stimState[1:0] == 2'd0) begin
                wbAck   <= 1'b1;
                wbDatIn <= mem[6'((wbAdr - `FETCH_RESET_ADDR) >> 2)];
            end else begin
                inCycle  <= 1'b1;
                waitLeft <= inCycle ? waitLeft - 2'd1 : stimState[1:0] - 2'd1;
            end
        end
        if (reset || stallAge(cycleCount) >= 0) begin
            insReady <= 1'b0;
        end else begin
            insReady <= stimState[4:2] != 3'd0;
        end
    end

    // Inputs only move on rising edges, so check on the falling one
    always @(negedge clk) begin
        if (reset && cycleCount > 0) begin
            assert (!wbCyc && !wbStb && !insValid) else begin
                otherErrors++;
                $display("%0t: bus cycle or instruction output active during reset", $time);
            end
        end
        if (!reset && wbCyc) begin
            assert (wbSel == 4'hf) else reportMismatch("wbSel", 32'hf, 32'(wbSel));
            assert (!wbWe) else reportMismatch("wbWe", 32'd0, 32'(wbWe));
        end
        if (!reset && wbCyc && wbAck) begin
            assert (wbAdr == `FETCH_RESET_ADDR + 32'(4 * acks))
                else reportMismatch("wbAdr", `FETCH_RESET_ADDR + 32'(4 * acks), wbAdr);
            acks++;
        end
        if (stallAge(cycleCount) >= 100) begin
            assert (!wbCyc) else begin
                otherErrors++;
                $display("%0t: bus read issued while the FIFO should be full", $time);
            end
        end
        if (!reset && insValid && insReady) begin
            expected = expectedInstr(accepted);
            assert (insWord == expected.word)
                else reportMismatch("insWord", expected.word, insWord);
            assert (insCompressed == expected.isCompressed)
                else reportMismatch("insCompressed", 32'(expected.isCompressed),
                                    32'(insCompressed));
            assert (insPc == expected.pc)
                else reportMismatch("insPc", expected.pc, insPc);
            // Step from the previous accepted PC by the reference length
            if (accepted > 0) begin
                assert (insPc - lastPc == (lastCompressed ? 32'd2 : 32'd4))
                    else reportMismatch("insPc step", lastCompressed ? 32'd2 : 32'd4,
                                        insPc - lastPc);
            end
            lastPc         = insPc;
            lastCompressed = expected.isCompressed;
            accepted++;
            parcelsOut += insCompressed ? 1 : 2;
        end
        // Runahead bounded by the FIFO plus the word buffer
        assert (2 * acks - parcelsOut <= `PARCEL_FIFO_DEPTH + 2) else begin
            otherErrors++;
            $display("%0t: more parcels in flight than the FIFO can hold", $time);
        end
    end

    initial begin
        logic [31:0]      x;
        int               pos;
        fetchPkg::parcelT lo;
        logic             timedOut;
        x = seed;
        for (int i = 0; i < memWords; i++) begin
            x = xorshift(x);
            mem[6'(i)]        = x;
            mem[6'(i)][1:0]   = x[7] ? fetchPkg::fullLengthCode : {1'b0, x[8]};
            mem[6'(i)][17:16] = x[9] ? fetchPkg::fullLengthCode : {x[10], 1'b0};
        end
        // Compressed then full in word 0, so the second instruction straddles
        mem[0][1:0]   = 2'b00;
        mem[0][17:16] = fetchPkg::fullLengthCode;
        pos = 0;
        while (pos < 2 * memWords) begin
            lo = parcelAt(pos);
            numInstr++;
            pos += (lo[1:0] == fetchPkg::fullLengthCode) ? 2 : 1;
        end

        wait (accepted >= numInstr || cycleCount >= cycleLimit);
        timedOut = accepted < numInstr;
        if (timedOut) begin
            $display("Timeout after %0d cycles, %0d of %0d instructions accepted",
                     cycleCount, accepted, numInstr);
        end
        $display("Errors: %0d value mismatches, %0d other failures",
                 valueErrors, otherErrors + int'(timedOut));
        if (valueErrors == 0 && otherErrors == 0 && !timedOut) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : fetchTb

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fetchTb -f all.f -o fetchSim \
    || { echo "Verilator build failed"; exit 1; }
simOut=$(./obj_dir/fetchSim)
echo "$simOut"
echo "$simOut" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/busPkg.sv ====
`default_nettype none

package busPkg;

    // Wishbone byte address
    typedef logic [31:0] addrT;

    // Wishbone data word
    typedef logic [31:0] wordT;

    // Byte lane select
    typedef logic [3:0] selT;

    // Instruction reads always take the whole word
    localparam selT selAll = 4'b1111;

endpackage : busPkg

`default_nettype wire

// ==== source/fetchBusMaster.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetchBusMaster (
    input  logic             clk,
    input  logic             reset,

    // Wishbone classic read master
    output logic             wbCyc,
    output logic             wbStb,
    output busPkg::addrT     wbAdr,
    output busPkg::selT      wbSel,
    input  busPkg::wordT     wbDatIn,
    input  logic             wbAck,

    // Parcel push handshake
    output logic             pushReq,
    input  logic             pushAck,
    output fetchPkg::parcelT pushData
);

    logic         busy;
    busPkg::addrT fetchAddr;

    busPkg::wordT wordBuf;
    logic         bufFull;
    logic         halfSel;

    logic         startRead;
    logic         busDone;
    logic         pushFire;

    // New read only once both parcels of the last word are gone
    assign startRead = !busy && !bufFull;
    assign busDone   = busy && wbAck;
    assign pushFire  = pushReq && pushAck;

    // Bus cycle and fetch address
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            fetchAddr <= `FETCH_RESET_ADDR;
        end else begin
            if (startRead) begin
                busy <= 1'b1;
            end else if (busDone) begin
                busy      <= 1'b0;
                fetchAddr <= fetchAddr + 32'd4;
            end
        end
    end

    // Buffer state, low half goes out first
    always_ff @(posedge clk) begin
        if (reset) begin
            bufFull <= 1'b0;
            halfSel <= 1'b0;
        end else begin
            if (busDone) begin
                bufFull <= 1'b1;
                halfSel <= 1'b0;
            end else if (pushFire) begin
                if (halfSel) begin
                    bufFull <= 1'b0;
                    halfSel <= 1'b0;
                end else begin
                    halfSel <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busDone) begin
            wordBuf <= wbDatIn;
        end
    end

    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbAdr = fetchAddr;
    assign wbSel = busPkg::selAll;

    assign pushReq  = bufFull;
    assign pushData = halfSel ? wordBuf[31:16] : wordBuf[15:0];

endmodule : fetchBusMaster

`default_nettype wire

// ==== source/fetchPkg.sv ====
`default_nettype none

package fetchPkg;

    // One 16-bit instruction parcel
    typedef logic [15:0] parcelT;

    // Low two bits of a parcel
    typedef logic [1:0] lengthCodeT;

    // Entries retired per pop, 1 or 2
    typedef logic [1:0] popOffsetT;

    // Length code of a 32-bit instruction
    localparam lengthCodeT fullLengthCode = 2'b11;

    // Assembled instruction with its address
    typedef struct packed {
        logic [31:0]   word;
        logic          isCompressed;
        busPkg::addrT  pc;
    } instructionT;

endpackage : fetchPkg

`default_nettype wire

// ==== source/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Byte address of the first fetch, word aligned
`define FETCH_RESET_ADDR 32'h0000_0000

// Parcel FIFO entries, power of two
`define PARCEL_FIFO_DEPTH 16

`endif

// ==== source/instructionAligner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module instructionAligner (
    input  logic                  clk,
    input  logic                  reset,

    parcelPopIf.consumer          pop,

    output logic                  insValid,
    input  logic                  insReady,
    output fetchPkg::instructionT insData
);

    fetchPkg::lengthCodeT lengthCode;
    logic                 isFull;
    busPkg::addrT         pc;
    busPkg::addrT         pcStep;

    // RISC-V style length from the head parcel
    assign lengthCode = pop.headData[1:0];
    assign isFull     = lengthCode == fetchPkg::fullLengthCode;

    // A full-length instruction waits for its second parcel
    assign insValid = pop.popReq && (!isFull || pop.nextValid);

    assign pop.popAck    = insValid && insReady;
    assign pop.popOffset = isFull ? 2'd2 : 2'd1;

    always_comb begin
        insData.isCompressed = !isFull;
        insData.pc           = pc;
        if (isFull) begin
            insData.word = {pop.nextData, pop.headData};
        end else begin
            insData.word = {16'h0000, pop.headData};
        end
    end

    assign pcStep = isFull ? 32'd4 : 32'd2;

    // PC of the instruction at the head
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FETCH_RESET_ADDR;
        end else if (pop.popAck) begin
            pc <= pc + pcStep;
        end
    end

endmodule : instructionAligner

`default_nettype wire

// ==== source/instructionFetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module instructionFetchUnit (
    input  logic         clk,
    input  logic         reset,

    output logic         wbCyc,
    output logic         wbStb,
    output logic         wbWe,
    output busPkg::addrT wbAdr,
    output busPkg::selT  wbSel,
    input  busPkg::wordT wbDatIn,
    input  logic         wbAck,

    output logic         insValid,
    input  logic         insReady,
    output logic [31:0]  insWord,
    output logic         insCompressed,
    output busPkg::addrT insPc
);

    logic                  pushReq;
    logic                  pushAck;
    fetchPkg::parcelT      pushData;
    fetchPkg::instructionT insData;

    parcelPopIf popBus ();

    // Read only master
    assign wbWe = 1'b0;

    fetchBusMaster i_fetchBusMaster (
        .clk      (clk),
        .reset    (reset),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbAdr    (wbAdr),
        .wbSel    (wbSel),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck),
        .pushReq  (pushReq),
        .pushAck  (pushAck),
        .pushData (pushData)
    );

    parcelFifo #(
        .depth (`PARCEL_FIFO_DEPTH)
    ) i_parcelFifo (
        .clk      (clk),
        .reset    (reset),
        .pushReq  (pushReq),
        .pushAck  (pushAck),
        .pushData (pushData),
        .pop      (popBus.fifo)
    );

    instructionAligner i_instructionAligner (
        .clk      (clk),
        .reset    (reset),
        .pop      (popBus.consumer),
        .insValid (insValid),
        .insReady (insReady),
        .insData  (insData)
    );

    assign insWord       = insData.word;
    assign insCompressed = insData.isCompressed;
    assign insPc         = insData.pc;

endmodule : instructionFetchUnit

`default_nettype wire

// ==== source/parcelFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module parcelFifo #(
    parameter int depth = 16
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             pushReq,
    output logic             pushAck,
    input  fetchPkg::parcelT pushData,

    parcelPopIf.fifo         pop
);

    localparam int indexBits = $clog2(depth);

    typedef logic [indexBits-1:0] indexT;
    typedef logic [indexBits:0]   countT;

    fetchPkg::parcelT mem [depth];

    indexT headIdx;
    indexT tailIdx;
    indexT nextIdx;

    countT count;
    countT nextCount;
    logic  full;
    logic  empty;
    logic  twoPlus;

    logic                pushFire;
    logic                popFire;
    fetchPkg::popOffsetT popCount;

    assign pushFire = pushReq && pushAck;
    assign popFire  = pop.popReq && pop.popAck;
    assign popCount = popFire ? pop.popOffset : 2'd0;

    // Head advances by one per push
    always_ff @(posedge clk) begin
        if (reset) begin
            headIdx <= '0;
        end else if (pushFire) begin
            headIdx <= headIdx + indexT'(1);
        end
    end

    // Tail retires one or two entries per pop
    always_ff @(posedge clk) begin
        if (reset) begin
            tailIdx <= '0;
        end else if (popFire) begin
            tailIdx <= tailIdx + indexT'(pop.popOffset);
        end
    end

    always_ff @(posedge clk) begin
        if (pushFire) begin
            mem[headIdx] <= pushData;
        end
    end

    // Occupancy with flags taken from the next count
    assign nextCount = count + countT'(pushFire) - countT'(popCount);

    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            full    <= 1'b0;
            empty   <= 1'b1;
            twoPlus <= 1'b0;
        end else begin
            count   <= nextCount;
            full    <= nextCount == countT'(depth);
            empty   <= nextCount == '0;
            twoPlus <= nextCount >= countT'(2);
        end
    end

    assign pushAck = !full;

    // Peek two entries so a straddling instruction is seen whole
    assign nextIdx       = tailIdx + indexT'(1);
    assign pop.popReq    = !empty;
    assign pop.headData  = mem[tailIdx];
    assign pop.nextData  = mem[nextIdx];
    assign pop.nextValid = twoPlus;

endmodule : parcelFifo

`default_nettype wire

// ==== source/parcelPopIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface parcelPopIf;

    // Head entry valid
    logic               popReq;
    // Parcel at the tail index and the one after it
    fetchPkg::parcelT   headData;
    fetchPkg::parcelT   nextData;
    // At least two entries held
    logic               nextValid;

    logic               popAck;
    fetchPkg::popOffsetT popOffset;

    modport fifo (
        output popReq,
        output headData,
        output nextData,
        output nextValid,
        input  popAck,
        input  popOffset
    );

    modport consumer (
        input  popReq,
        input  headData,
        input  nextData,
        input  nextValid,
        output popAck,
        output popOffset
    );

endinterface : parcelPopIf

`default_nettype wire
